//--- Makefile
# Verilator build, run and lint for the four-way arbiter

SIM      := verilator
FLAGS    := --timing
TOP      := arb_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/arb_ref.svh
/*
  Reference model for the arbiter
  LFSR step, favored-order and round-robin picks, and the expected grant
  for one cycle given the inputs, the LFSR state and the last grant
*/
`ifndef ARB_REF_SVH
`define ARB_REF_SVH

// New stage one from stages one and three, the rest shift up
function automatic logic [lfsr_w-1:0] lfsr_step(input logic [lfsr_w-1:0] s);
  return {s[1], s[0], s[0] ^ s[2]};
endfunction

function automatic logic [req_idx_w-1:0] lfsr_index(input logic [lfsr_w-1:0] s);
  return {s[2], s[1]};  // Stage three high
endfunction

// Favored first, then ascending index
function automatic logic [num_req-1:0] favored_pick(input logic [num_req-1:0]   r,
                                                    input logic [req_idx_w-1:0] fav);
  logic [num_req-1:0]   g;
  logic [req_idx_w-1:0] idx;

  g   = '0;
  idx = '0;
  if (r[fav]) begin
    g[fav] = 1'b1;
  end else begin
    repeat (num_req) begin
      if (r[idx] && g == '0) begin
        g[idx] = 1'b1;
      end
      idx = idx + 1'b1;
    end
  end
  return g;
endfunction

// Search starts one past the last grant and wraps
function automatic logic [num_req-1:0] round_robin_pick(input logic [num_req-1:0]   r,
                                                        input logic [req_idx_w-1:0] last);
  logic [num_req-1:0]   g;
  logic [req_idx_w-1:0] idx;

  g   = '0;
  idx = last;
  repeat (num_req) begin
    idx = idx + 1'b1;
    if (r[idx] && g == '0) begin
      g[idx] = 1'b1;
    end
  end
  return g;
endfunction

function automatic logic [req_idx_w-1:0] grant_index(input logic [num_req-1:0] g);
  logic [req_idx_w-1:0] idx;
  logic [req_idx_w-1:0] k;

  idx = '0;
  k   = '0;
  repeat (num_req) begin
    if (g[k]) begin
      idx = k;
    end
    k = k + 1'b1;
  end
  return idx;
endfunction

function automatic logic [num_req-1:0] expected_grant(input logic [num_req-1:0]   r,
                                                      input logic [mode_w-1:0]    mode,
                                                      input logic [lfsr_w-1:0]    s,
                                                      input logic [req_idx_w-1:0] last);
  logic [num_req-1:0] g;

  case (mode)
    mode_fix0, mode_fix1, mode_fix2, mode_fix3: g = favored_pick(r, mode[1:0]);
    mode_rand: g = favored_pick(r, lfsr_index(s));
    mode_rr:   g = round_robin_pick(r, last);
    default:   g = '0;  // Codes 6 and 7
  endcase
  return g;
endfunction

`endif

//--- bench/arb_tb.sv
/*
  Testbench for the four-way arbiter
  Drives LCG requests and modes, and compares gnt every cycle against a
  reference model that keeps its own LFSR and last-grant index
*/
`timescale 1ns/1ns

module arb_tb;

  import arb_cfg_pkg::*;
  import arb_mode_pkg::*;

  `include "arb_ref.svh"

  localparam int reset_timeout = 20;
  localparam int drain_timeout = 20;
  localparam int mixed_cycles  = 2000;

  logic               clk = 1'b0;
  logic               rst_n;
  logic [num_req-1:0] req;
  logic [mode_w-1:0]  arb_type;
  logic [num_req-1:0] gnt;

  // Reference state that tracks the DUT one edge at a time
  logic [lfsr_w-1:0]    ref_lfsr;
  logic [req_idx_w-1:0] ref_last;
  logic [num_req-1:0]   exp_gnt;
  logic [num_req-1:0]   req_q;
  int                   checks_done = 0;

  logic [31:0] lcg_state = 32'd82;

  arb_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .gnt      (gnt)
  );

  always #10 clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_word(output logic [31:0] w);
    lcg_state = lcg_next(lcg_state);
    w         = lcg_state;
  endtask

  // Inputs change after the edge and are sampled at the next one
  task automatic drive(input logic [num_req-1:0] r, input logic [mode_w-1:0] m);
    @(posedge clk);
    req      <= r;
    arb_type <= m;
  endtask

  task automatic settle_and_sample(output logic [num_req-1:0] g);
    @(posedge clk);
    @(negedge clk);
    g = gnt;
  endtask

  task automatic wait_reset_release();
    int cycles;

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < reset_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1, "reset timeout");
    end
  endtask

  task automatic wait_checks_drained(input int target, output bit drained);
    int cycles;

    cycles = 0;
    while (checks_done < target && cycles < drain_timeout) begin
      @(posedge clk);
      cycles++;
    end
    drained = (checks_done >= target);
  endtask

  // Reference model and comparison on pre-edge values
  always @(posedge clk) begin
    logic [num_req-1:0] exp_now;

    if (!rst_n) begin
      ref_lfsr <= lfsr_seed;
      ref_last <= '0;
      exp_gnt  <= '0;
      req_q    <= '0;
    end else begin
      check_value(32'(gnt), 32'(exp_gnt), "gnt against reference");
      check_value(32'(gnt & ~req_q), 32'd0, "grant to a requester not asking");
      check_value(32'(gnt & (gnt - 4'd1)), 32'd0, "grant not one-hot");
      exp_now     = expected_grant(req, arb_type, ref_lfsr, ref_last);
      exp_gnt     <= exp_now;
      ref_lfsr    <= lfsr_step(ref_lfsr);
      ref_last    <= grant_index(exp_now);  // From own expectation
      req_q       <= req;
      checks_done <= checks_done + 1;
    end
  end

  initial begin
    logic [31:0]        w;
    logic [num_req-1:0] g;
    logic [num_req-1:0] prev;
    logic [mode_w-1:0]  mode;
    int                 target;
    bit                 drained;

    req      = '0;
    arb_type = mode_fix0;
    wait_reset_release();

    // No requests in any mode
    for (int m = 0; m < 8; m++) begin
      drive('0, mode_w'(m));
      drive('0, mode_w'(m));
    end

    // Fixed modes, every request pattern
    for (int m = 0; m < 4; m++) begin
      for (int p = 0; p < 16; p++) begin
        drive(num_req'(p), mode_w'(m));
      end
    end

    drive(4'b0101, mode_fix2);
    settle_and_sample(g);
    check_value(32'(g), 32'(4'b0100), "mode 2 with requests 0 and 2");

    // Full load round robin walks one step per cycle
    drive('1, mode_rr);
    settle_and_sample(prev);
    check_value(32'(prev == '0), 32'd0, "no round-robin grant under full load");
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      g = gnt;
      check_value(32'(g), 32'({prev[2:0], prev[3]}), "round-robin rotation");
      prev = g;
    end

    for (int i = 0; i < 200; i++) begin
      random_word(w);
      drive(w[31:28] & w[27:24], mode_rr);  // Sparse
    end

    // Random mode follows the LFSR from its seed
    for (int i = 0; i < 3; i++) begin
      for (int p = 0; p < 16; p++) begin
        drive(num_req'(p), mode_rand);
      end
    end
    for (int i = 0; i < 100; i++) begin
      random_word(w);
      drive(w[31:28], mode_rand);
    end

    // Unused codes
    for (int i = 0; i < 20; i++) begin
      random_word(w);
      drive(w[31:28] | 4'b0001, 3'd6);
      drive(w[27:24] | 4'b1000, 3'd7);
    end

    // Mode switches under random traffic
    mode = mode_fix0;
    for (int i = 0; i < mixed_cycles; i++) begin
      random_word(w);
      if (w[23:22] == 2'b00) begin
        mode = w[18:16];
      end
      drive(w[15] ? w[31:28] : (w[31:28] & w[27:24]), mode);
    end

    drive('0, mode_fix0);
    target = checks_done + 3;
    wait_checks_drained(target, drained);
    if (drained) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("comparisons stopped before the run finished");
      $display("TEST FAILED");
      $fatal(1, "run did not finish");
    end
  end

endmodule

//--- build.f
+incdir+bench
logic/arb_cfg_pkg.sv
logic/arb_mode_pkg.sv
logic/pn_seq_gen.sv
logic/favored_grant.sv
logic/rotating_grant.sv
logic/grant_select.sv
logic/arb_top.sv
bench/arb_tb.sv

//--- logic/arb_cfg_pkg.sv
/*
  Arbiter configuration constants
  Requester count, index width and the LFSR shape used by the random scheme
*/
package arb_cfg_pkg;

  // Four requesters, indexed by two bits
  localparam int num_req   = 4;
  localparam int req_idx_w = 2;

  // Three-stage LFSR, stage one is bit 0
  localparam int lfsr_w = 3;

  // Stage one high after reset
  localparam logic [lfsr_w-1:0] lfsr_seed = 3'b001;

endpackage

//--- logic/arb_mode_pkg.sv
/*
  Arbitration mode codes
  Encoding of arb_type as seen by the favored and round-robin paths
*/
package arb_mode_pkg;

  localparam int mode_w = 3;

  // Fixed priority, low two bits name the favored requester
  localparam logic [mode_w-1:0] mode_fix0 = 3'd0;
  localparam logic [mode_w-1:0] mode_fix1 = 3'd1;
  localparam logic [mode_w-1:0] mode_fix2 = 3'd2;
  localparam logic [mode_w-1:0] mode_fix3 = 3'd3;

  localparam logic [mode_w-1:0] mode_rr   = 3'd4;  // Round robin

  // Favored requester taken from the LFSR
  localparam logic [mode_w-1:0] mode_rand = 3'd5;

  // Codes 6 and 7 grant nothing

endpackage

//--- logic/arb_top.sv
/*
  Four-way arbiter with run-time selectable grant scheme
  Favored and round-robin paths run side by side, the selector
  registers the chosen grant one cycle after the request
*/
`timescale 1ns/1ns

module arb_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [arb_cfg_pkg::num_req-1:0] req,
  input  logic [arb_mode_pkg::mode_w-1:0] arb_type,
  output logic [arb_cfg_pkg::num_req-1:0] gnt
);

  import arb_cfg_pkg::*;

  logic [num_req-1:0]   fav_gnt;
  logic [num_req-1:0]   rr_gnt;
  logic [req_idx_w-1:0] last_idx;  // From registered gnt

  favored_grant u_fav (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .fav_gnt  (fav_gnt)
  );

  rotating_grant u_rr (
    .req      (req),
    .last_idx (last_idx),
    .rr_gnt   (rr_gnt)
  );

  grant_select u_sel (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .fav_gnt  (fav_gnt),
    .rr_gnt   (rr_gnt),
    .gnt      (gnt),
    .last_idx (last_idx)
  );

endmodule

//--- logic/favored_grant.sv
/*
  Favored-requester grant path
  One priority encoder covers the four fixed schemes and the random one.
  The favored requester wins if asking, then the rest in ascending index.
*/
`timescale 1ns/1ns

module favored_grant (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [arb_cfg_pkg::num_req-1:0]   req,
  input  logic [arb_mode_pkg::mode_w-1:0]   arb_type,
  output logic [arb_cfg_pkg::num_req-1:0]   fav_gnt
);

  import arb_cfg_pkg::*;
  import arb_mode_pkg::*;

  logic [req_idx_w-1:0] rand_idx;
  logic [req_idx_w-1:0] fav_idx;

  pn_seq_gen u_pn (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  // Fixed modes carry the index in their low bits
  always_comb begin
    if (arb_type == mode_rand) begin
      fav_idx = rand_idx;
    end else begin
      fav_idx = arb_type[req_idx_w-1:0];
    end
  end

  always_comb begin
    logic hit;

    fav_gnt = '0;
    hit     = 1'b0;

    if (req[fav_idx]) begin
      fav_gnt[fav_idx] = 1'b1;
      hit              = 1'b1;
    end

    // Fall back to lowest index
    for (int i = 0; i < num_req; i++) begin
      if (!hit && req[i]) begin
        fav_gnt[i] = 1'b1;
        hit        = 1'b1;
      end
    end
  end

endmodule

//--- logic/grant_select.sv
/*
  Grant selector and register
  Chooses the favored or round-robin result by mode, registers it as gnt
  and encodes the registered grant for the round-robin path
*/
`timescale 1ns/1ns

module grant_select (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [arb_mode_pkg::mode_w-1:0]   arb_type,
  input  logic [arb_cfg_pkg::num_req-1:0]   fav_gnt,
  input  logic [arb_cfg_pkg::num_req-1:0]   rr_gnt,
  output logic [arb_cfg_pkg::num_req-1:0]   gnt,
  output logic [arb_cfg_pkg::req_idx_w-1:0] last_idx
);

  import arb_cfg_pkg::*;
  import arb_mode_pkg::*;

  logic [num_req-1:0] gnt_d;

  always_comb begin
    case (arb_type)
      mode_fix0, mode_fix1,
      mode_fix2, mode_fix3: gnt_d = fav_gnt;
      mode_rand:            gnt_d = fav_gnt;  // Same encoder, LFSR index
      mode_rr:              gnt_d = rr_gnt;
      default:              gnt_d = '0;       // Unused codes
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      gnt <= gnt_d;
    end
  end

  // One-hot to index, zero when idle
  always_comb begin
    last_idx = '0;
    for (int i = 0; i < num_req; i++) begin
      if (gnt[i]) begin
        last_idx = req_idx_w'(i);
      end
    end
  end

endmodule

//--- logic/pn_seq_gen.sv
/*
  Pseudo-random requester index
  Three-stage Fibonacci LFSR, period of 7, stepping every cycle
*/
`timescale 1ns/1ns

module pn_seq_gen (
  input  logic                            clk,
  input  logic                            rst_n,
  output logic [arb_cfg_pkg::req_idx_w-1:0] rand_idx
);

  import arb_cfg_pkg::*;

  logic [lfsr_w-1:0] lfsr_q;
  logic              fb;

  // Taps on stages one and three
  assign fb = lfsr_q[0] ^ lfsr_q[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= lfsr_seed;
    end else begin
      lfsr_q[0] <= fb;
      lfsr_q[1] <= lfsr_q[0];
      lfsr_q[2] <= lfsr_q[1];
    end
  end

  // Stage three is the high bit
  assign rand_idx = {lfsr_q[2], lfsr_q[1]};

endmodule

//--- logic/rotating_grant.sv
/*
  Round-robin grant path
  Rotates req so the search begins just after the last grant, picks the
  lowest set bit and rotates the one-hot result back into place
*/
`timescale 1ns/1ns

module rotating_grant (
  input  logic [arb_cfg_pkg::num_req-1:0]   req,
  input  logic [arb_cfg_pkg::req_idx_w-1:0] last_idx,
  output logic [arb_cfg_pkg::num_req-1:0]   rr_gnt
);

  import arb_cfg_pkg::*;

  logic [req_idx_w-1:0] start;
  logic [num_req-1:0]   rot_req;
  logic [num_req-1:0]   rot_gnt;

  // Wraps modulo four through the index width
  assign start = last_idx + 1'b1;

  // Bit 0 of rot_req is the first requester searched
  always_comb begin
    logic [req_idx_w-1:0] pos;

    rot_req = '0;
    for (int i = 0; i < num_req; i++) begin
      pos        = req_idx_w'(i) + start;
      rot_req[i] = req[pos];
    end
  end

  // Isolate lowest set bit
  assign rot_gnt = rot_req & (~rot_req + 1'b1);

  // Undo the rotation
  always_comb begin
    logic [req_idx_w-1:0] pos;

    rr_gnt = '0;
    for (int i = 0; i < num_req; i++) begin
      pos         = req_idx_w'(i) + start;
      rr_gnt[pos] = rot_gnt[i];
    end
  end

endmodule
